//--- tb.f
+incdir+testbench
design/valu_pkg.sv
design/valu_simd_alu.sv
design/valu_insn_queue.sv
design/valu_issue_ctrl.sv
design/valu_result_queue.sv
design/valu_top.sv
testbench/tb_valu.sv

//--- Bender.yml
package:
  name: valu

sources:
  - files:
      - design/valu_pkg.sv
      - design/valu_simd_alu.sv
      - design/valu_insn_queue.sv
      - design/valu_issue_ctrl.sv
      - design/valu_result_queue.sv
      - design/valu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_valu.sv

//--- testbench/tb_valu_model.svh
// Lane reference model; include inside tb_valu after the valu_pkg import, uses its VRegWords
`ifndef TB_VALU_MODEL_SVH
`define TB_VALU_MODEL_SVH

////////////////////////////////////////
// Element accounting
////////////////////////////////////////

// Elements that fit in one 64-bit word
function automatic int unsigned elems_per_word(vsew_e sew);
  return 8 >> int'(sew);
endfunction

// Words needed for vl elements, partial last word counted
function automatic int unsigned words_for_vl(vlen_t vl, vsew_e sew);
  return (int'(vl) + elems_per_word(sew) - 1) / elems_per_word(sew);
endfunction

// Bytes of the elements that word widx still holds
function automatic strb_t expected_be(vlen_t vl, vsew_e sew, int unsigned widx);
  int unsigned left;
  int unsigned n;
  int unsigned nbytes;
  strb_t       be;
  left   = int'(vl) - widx * elems_per_word(sew);
  n      = (left < elems_per_word(sew)) ? left : elems_per_word(sew);
  nbytes = n << int'(sew);
  be     = '0;
  for (int unsigned i = 0; i < nbytes; i++) begin
    be[i] = 1'b1;
  end
  return be;
endfunction

// Register base plus word index
function automatic int unsigned expected_addr(vreg_t vd, int unsigned widx);
  return int'(vd) * VRegWords + widx;
endfunction

////////////////////////////////////////
// Element arithmetic
////////////////////////////////////////

// Low element of the scalar repeated across the word
function automatic elen_t broadcast_scalar(elen_t scalar, vsew_e sew);
  int unsigned ew;
  elen_t       mask;
  elen_t       res;
  ew   = 8 << int'(sew);
  mask = (ew == 64) ? '1 : ((64'd1 << ew) - 1);
  res  = '0;
  for (int unsigned i = 0; i < 64 / ew; i++) begin
    res = res | ((scalar & mask) << (i * ew));
  end
  return res;
endfunction

// One element at a time, each wrapped to its own width
function automatic elen_t word_result(alu_op_e op, vsew_e sew, elen_t a, elen_t b);
  int unsigned ew;
  elen_t       mask;
  elen_t       ea;
  elen_t       eb;
  elen_t       er;
  elen_t       res;
  ew   = 8 << int'(sew);
  mask = (ew == 64) ? '1 : ((64'd1 << ew) - 1);
  res  = '0;
  for (int unsigned i = 0; i < 64 / ew; i++) begin
    ea = (a >> (i * ew)) & mask;
    eb = (b >> (i * ew)) & mask;
    case (op)
      OP_ADD:  er = ea + eb;
      OP_SUB:  er = ea - eb;
      OP_AND:  er = ea & eb;
      OP_OR:   er = ea | eb;
      OP_XOR:  er = ea ^ eb;
      OP_MINU: er = (ea < eb) ? ea : eb;
      default: er = '0;
    endcase
    res = res | ((er & mask) << (i * ew));
  end
  return res;
endfunction

`endif

//--- testbench/tb_valu.sv
// Seeded random run of the lane; stimulus on falling edges, stops at the first mismatch
`timescale 1ns/1ps

module tb_valu;

  import valu_pkg::*;

  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned VAddrWidth     = 10;
  localparam int unsigned VRegWords      = 16;
  localparam int unsigned Seed           = 43;
  localparam int unsigned NumInsns       = 60;
  // Cycles with no accept and no grant before the run is abandoned
  localparam int unsigned StallLimit     = 500;

  `include "tb_valu_model.svh"

  logic                  clk_i;
  logic                  rst_ni;
  logic                  insn_valid_i;
  logic                  insn_ready_o;
  alu_op_e               insn_op_i;
  vsew_e                 insn_vsew_i;
  vlen_t                 insn_vl_i;
  vreg_t                 insn_vd_i;
  vid_t                  insn_id_i;
  logic                  insn_use_scalar_i;
  elen_t                 insn_scalar_i;
  elen_t                 opa_i;
  logic                  opa_valid_i;
  logic                  opa_ready_o;
  elen_t                 opb_i;
  logic                  opb_valid_i;
  logic                  opb_ready_o;
  logic                  res_req_o;
  vid_t                  res_id_o;
  logic [VAddrWidth-1:0] res_addr_o;
  elen_t                 res_wdata_o;
  strb_t                 res_be_o;
  logic                  res_gnt_i;
  logic [NrInsnIds-1:0]  done_o;

  valu_top #(
    .InsnQueueDepth (InsnQueueDepth),
    .VAddrWidth     (VAddrWidth),
    .VRegWords      (VRegWords)
  ) uut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_valid_i      (insn_valid_i),
    .insn_ready_o      (insn_ready_o),
    .insn_op_i         (insn_op_i),
    .insn_vsew_i       (insn_vsew_i),
    .insn_vl_i         (insn_vl_i),
    .insn_vd_i         (insn_vd_i),
    .insn_id_i         (insn_id_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .opa_i             (opa_i),
    .opa_valid_i       (opa_valid_i),
    .opa_ready_o       (opa_ready_o),
    .opb_i             (opb_i),
    .opb_valid_i       (opb_valid_i),
    .opb_ready_o       (opb_ready_o),
    .res_req_o         (res_req_o),
    .res_id_o          (res_id_o),
    .res_addr_o        (res_addr_o),
    .res_wdata_o       (res_wdata_o),
    .res_be_o          (res_be_o),
    .res_gnt_i         (res_gnt_i),
    .done_o            (done_o)
  );

  ////////////////////////////////////////
  // Model state
  ////////////////////////////////////////

  // Expected words in grant order
  vid_t                  exp_id   [$];
  logic [VAddrWidth-1:0] exp_addr [$];
  elen_t                 exp_data [$];
  strb_t                 exp_be   [$];
  logic                  exp_last [$];
  // Accepted instructions still issuing with the head at index 0
  alu_op_e     iss_op     [$];
  vsew_e       iss_sew    [$];
  vlen_t       iss_vl     [$];
  vreg_t       iss_vd     [$];
  vid_t        iss_id     [$];
  logic        iss_use    [$];
  elen_t       iss_scalar [$];
  int unsigned iss_widx;

  int unsigned outstanding;
  int unsigned sent;
  int unsigned finished;
  int unsigned full_seen;
  int unsigned idle;
  int unsigned gnt_left;
  logic        gnt_low;
  logic        insn_taken;

  // Request seen waiting for its grant
  logic                  held_req;
  vid_t                  held_id;
  logic [VAddrWidth-1:0] held_addr;
  elen_t                 held_data;
  strb_t                 held_be;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic drive_inputs();
    if (insn_taken) begin
      insn_valid_i = 1'b0;
      insn_taken   = 1'b0;
    end
    // New instruction held until accepted
    if (!insn_valid_i && sent < NumInsns && $urandom_range(3) != 0) begin
      insn_valid_i      = 1'b1;
      insn_op_i         = alu_op_e'($urandom_range(5));
      insn_vsew_i       = vsew_e'($urandom_range(3));
      insn_vl_i         = vlen_t'($urandom_range(40, 1));
      insn_vd_i         = vreg_t'($urandom_range(31));
      insn_id_i         = vid_t'($urandom_range(NrInsnIds - 1));
      insn_use_scalar_i = ($urandom_range(3) == 0);
      insn_scalar_i     = {$urandom, $urandom};
    end
    opa_valid_i = ($urandom_range(3) != 0);
    opa_i       = {$urandom, $urandom};
    opb_valid_i = ($urandom_range(3) != 0);
    opb_i       = {$urandom, $urandom};
    // Grant runs in stretches and the long ones are held low
    if (gnt_left == 0) begin
      gnt_low  = ($urandom_range(4) == 0);
      gnt_left = gnt_low ? $urandom_range(40, 15) : $urandom_range(12, 1);
    end
    gnt_left--;
    res_gnt_i = gnt_low ? 1'b0 : ($urandom_range(3) != 0);
  endtask

  ////////////////////////////////////////
  // Checks sampled a quarter cycle after driving
  ////////////////////////////////////////

  task automatic sample_and_check();
    elen_t                a_word;
    int unsigned          nwords;
    logic [NrInsnIds-1:0] exp_done;
    assert (insn_ready_o == (outstanding < InsnQueueDepth))
      else report_mismatch("insn_ready_o", insn_ready_o, outstanding < InsnQueueDepth);
    if (!insn_ready_o) begin
      full_seen++;
    end
    // Waiting request keeps its payload
    if (held_req) begin
      assert (res_req_o) else report_failure("res_req_o dropped before its grant");
      assert (res_id_o == held_id) else report_mismatch("res_id_o", res_id_o, held_id);
      assert (res_addr_o == held_addr) else report_mismatch("res_addr_o", res_addr_o, held_addr);
      assert (res_wdata_o == held_data)
        else report_mismatch("res_wdata_o", res_wdata_o, held_data);
      assert (res_be_o == held_be) else report_mismatch("res_be_o", res_be_o, held_be);
    end
    held_req  = res_req_o && !res_gnt_i;
    held_id   = res_id_o;
    held_addr = res_addr_o;
    held_data = res_wdata_o;
    held_be   = res_be_o;
    // One word issues when opb is taken
    if (opb_ready_o) begin
      assert (iss_op.size() > 0) else report_failure("operand taken with nothing to issue");
      assert (opb_valid_i) else report_failure("opb_ready_o high while opb is not valid");
      assert (iss_use[0] || opa_valid_i)
        else report_failure("word issued while opa is not valid");
      assert (opa_ready_o == !iss_use[0])
        else report_mismatch("opa_ready_o", opa_ready_o, !iss_use[0]);
      a_word = iss_use[0] ? broadcast_scalar(iss_scalar[0], iss_sew[0]) : opa_i;
      nwords = words_for_vl(iss_vl[0], iss_sew[0]);
      exp_id.push_back(iss_id[0]);
      exp_addr.push_back(VAddrWidth'(expected_addr(iss_vd[0], iss_widx)));
      exp_data.push_back(word_result(iss_op[0], iss_sew[0], a_word, opb_i));
      exp_be.push_back(expected_be(iss_vl[0], iss_sew[0], iss_widx));
      exp_last.push_back(iss_widx + 1 == nwords);
      iss_widx++;
      if (iss_widx == nwords) begin
        iss_op.pop_front();
        iss_sew.pop_front();
        iss_vl.pop_front();
        iss_vd.pop_front();
        iss_id.pop_front();
        iss_use.pop_front();
        iss_scalar.pop_front();
        iss_widx = 0;
      end
    end else begin
      assert (!opa_ready_o) else report_failure("opa_ready_o high while opb is not taken");
    end
    // Granted word against the oldest expected one
    exp_done = '0;
    if (res_req_o && res_gnt_i) begin
      assert (exp_id.size() > 0) else report_failure("word granted that never issued");
      assert (res_id_o == exp_id[0]) else report_mismatch("res_id_o", res_id_o, exp_id[0]);
      assert (res_addr_o == exp_addr[0])
        else report_mismatch("res_addr_o", res_addr_o, exp_addr[0]);
      assert (res_wdata_o == exp_data[0])
        else report_mismatch("res_wdata_o", res_wdata_o, exp_data[0]);
      assert (res_be_o == exp_be[0]) else report_mismatch("res_be_o", res_be_o, exp_be[0]);
      if (exp_last[0]) begin
        exp_done[exp_id[0]] = 1'b1;
        finished++;
        outstanding--;
      end
      exp_id.pop_front();
      exp_addr.pop_front();
      exp_data.pop_front();
      exp_be.pop_front();
      exp_last.pop_front();
      idle = 0;
    end
    assert (done_o == exp_done) else report_mismatch("done_o", done_o, exp_done);
    // Accepted at the coming edge and issuable from the one after it
    if (insn_valid_i && insn_ready_o) begin
      iss_op.push_back(insn_op_i);
      iss_sew.push_back(insn_vsew_i);
      iss_vl.push_back(insn_vl_i);
      iss_vd.push_back(insn_vd_i);
      iss_id.push_back(insn_id_i);
      iss_use.push_back(insn_use_scalar_i);
      iss_scalar.push_back(insn_scalar_i);
      outstanding++;
      sent++;
      insn_taken = 1'b1;
      idle       = 0;
    end
  endtask

  task automatic check_reset_state();
    assert (!res_req_o) else report_mismatch("res_req_o", res_req_o, 0);
    assert (!opa_ready_o) else report_mismatch("opa_ready_o", opa_ready_o, 0);
    assert (!opb_ready_o) else report_mismatch("opb_ready_o", opb_ready_o, 0);
    assert (done_o == '0) else report_mismatch("done_o", done_o, 0);
    assert (insn_ready_o) else report_mismatch("insn_ready_o", insn_ready_o, 1);
  endtask

  initial begin
    rst_ni            = 1'b0;
    insn_valid_i      = 1'b0;
    insn_op_i         = OP_ADD;
    insn_vsew_i       = EW8;
    insn_vl_i         = '0;
    insn_vd_i         = '0;
    insn_id_i         = '0;
    insn_use_scalar_i = 1'b0;
    insn_scalar_i     = '0;
    opa_i             = '0;
    opa_valid_i       = 1'b0;
    opb_i             = '0;
    opb_valid_i       = 1'b0;
    res_gnt_i         = 1'b0;
    void'($urandom(Seed));
    iss_widx          = 0;
    outstanding       = 0;
    sent              = 0;
    finished          = 0;
    full_seen         = 0;
    idle              = 0;
    gnt_left          = 0;
    gnt_low           = 1'b0;
    insn_taken        = 1'b0;
    held_req          = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #5;
    check_reset_state();
    while (finished < NumInsns) begin
      @(negedge clk_i);
      drive_inputs();
      #5;
      sample_and_check();
      idle++;
      if (idle > StallLimit) begin
        report_failure("timeout, no instruction accepted and no word granted");
      end
    end
    // Drained lane has no request left
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    opa_valid_i  = 1'b0;
    opb_valid_i  = 1'b0;
    #5;
    assert (!res_req_o) else report_failure("result request left after the last done");
    assert (full_seen > 0) else report_failure("instruction queue never filled");
    $display("Regression passed");
    $finish;
  end

endmodule

//--- design/valu_top.sv
// Single-lane vector ALU; operands arrive in element order and vl of zero is not supported
`timescale 1ns/1ps

module valu_top #(
  parameter int unsigned InsnQueueDepth = 4,
  parameter int unsigned VAddrWidth     = 10,
  parameter int unsigned VRegWords      = 16
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Instruction port
  input  logic                            insn_valid_i,
  output logic                            insn_ready_o,
  input  valu_pkg::alu_op_e               insn_op_i,
  input  valu_pkg::vsew_e                 insn_vsew_i,
  input  valu_pkg::vlen_t                 insn_vl_i,
  input  valu_pkg::vreg_t                 insn_vd_i,
  input  valu_pkg::vid_t                  insn_id_i,
  input  logic                            insn_use_scalar_i,
  input  valu_pkg::elen_t                 insn_scalar_i,
  // Operand ports
  input  valu_pkg::elen_t                 opa_i,
  input  logic                            opa_valid_i,
  output logic                            opa_ready_o,
  input  valu_pkg::elen_t                 opb_i,
  input  logic                            opb_valid_i,
  output logic                            opb_ready_o,
  // Register file write port
  output logic                            res_req_o,
  output valu_pkg::vid_t                  res_id_o,
  output logic [VAddrWidth-1:0]           res_addr_o,
  output valu_pkg::elen_t                 res_wdata_o,
  output valu_pkg::strb_t                 res_be_o,
  input  logic                            res_gnt_i,
  // Per-id completion pulse
  output logic [valu_pkg::NrInsnIds-1:0]  done_o
);

  import valu_pkg::*;

  ////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////

  // Issue head
  logic    issue_valid;
  alu_op_e issue_op;
  vsew_e   issue_vsew;
  vlen_t   issue_vl;
  vreg_t   issue_vd;
  vid_t    issue_id;
  logic    issue_use_scalar;
  elen_t   issue_scalar;
  logic    issue_done;

  // Result queue write side
  logic                  push;
  vid_t                  push_id;
  logic [VAddrWidth-1:0] push_addr;
  elen_t                 push_wdata;
  strb_t                 push_be;
  logic                  rq_full;
  logic                  pop;

  valu_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .insn_valid_i       (insn_valid_i),
    .insn_ready_o       (insn_ready_o),
    .insn_op_i          (insn_op_i),
    .insn_vsew_i        (insn_vsew_i),
    .insn_vl_i          (insn_vl_i),
    .insn_vd_i          (insn_vd_i),
    .insn_id_i          (insn_id_i),
    .insn_use_scalar_i  (insn_use_scalar_i),
    .insn_scalar_i      (insn_scalar_i),
    .issue_valid_o      (issue_valid),
    .issue_op_o         (issue_op),
    .issue_vsew_o       (issue_vsew),
    .issue_vl_o         (issue_vl),
    .issue_vd_o         (issue_vd),
    .issue_id_o         (issue_id),
    .issue_use_scalar_o (issue_use_scalar),
    .issue_scalar_o     (issue_scalar),
    .issue_done_i       (issue_done),
    .pop_i              (pop),
    .done_o             (done_o)
  );

  valu_issue_ctrl #(
    .VAddrWidth (VAddrWidth),
    .VRegWords  (VRegWords)
  ) i_issue_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .issue_valid_i      (issue_valid),
    .issue_op_i         (issue_op),
    .issue_vsew_i       (issue_vsew),
    .issue_vl_i         (issue_vl),
    .issue_vd_i         (issue_vd),
    .issue_id_i         (issue_id),
    .issue_use_scalar_i (issue_use_scalar),
    .issue_scalar_i     (issue_scalar),
    .opa_valid_i        (opa_valid_i),
    .opb_valid_i        (opb_valid_i),
    .opa_i              (opa_i),
    .opb_i              (opb_i),
    .opa_ready_o        (opa_ready_o),
    .opb_ready_o        (opb_ready_o),
    .issue_done_o       (issue_done),
    .rq_full_i          (rq_full),
    .push_o             (push),
    .push_id_o          (push_id),
    .push_addr_o        (push_addr),
    .push_be_o          (push_be),
    .push_wdata_o       (push_wdata)
  );

  valu_result_queue #(
    .VAddrWidth (VAddrWidth)
  ) i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_id_i    (push_id),
    .push_addr_i  (push_addr),
    .push_wdata_i (push_wdata),
    .push_be_i    (push_be),
    .full_o       (rq_full),
    .res_req_o    (res_req_o),
    .res_id_o     (res_id_o),
    .res_addr_o   (res_addr_o),
    .res_wdata_o  (res_wdata_o),
    .res_be_o     (res_be_o),
    .res_gnt_i    (res_gnt_i),
    .pop_o        (pop)
  );

endmodule

//--- design/valu_result_queue.sv
// Two-entry FIFO in front of the register file; a pending request holds until granted
`timescale 1ns/1ps

module valu_result_queue #(
  parameter int unsigned VAddrWidth = 10
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Write side from the issue controller
  input  logic                    push_i,
  input  valu_pkg::vid_t          push_id_i,
  input  logic [VAddrWidth-1:0]   push_addr_i,
  input  valu_pkg::elen_t         push_wdata_i,
  input  valu_pkg::strb_t         push_be_i,
  output logic                    full_o,
  // Register file write port
  output logic                    res_req_o,
  output valu_pkg::vid_t          res_id_o,
  output logic [VAddrWidth-1:0]   res_addr_o,
  output valu_pkg::elen_t         res_wdata_o,
  output valu_pkg::strb_t         res_be_o,
  input  logic                    res_gnt_i,
  output logic                    pop_o
);

  import valu_pkg::*;

  localparam int unsigned ResultQueueDepth = 2;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  vid_t                  id_q    [ResultQueueDepth];
  logic [VAddrWidth-1:0] addr_q  [ResultQueueDepth];
  elen_t                 wdata_q [ResultQueueDepth];
  strb_t                 be_q    [ResultQueueDepth];

  // One entry per pointer bit
  logic       write_pnt_q;
  logic       read_pnt_q;
  logic [1:0] cnt_q;

  assign full_o = (cnt_q == 2'(ResultQueueDepth));

  // Head entry drives the request
  assign res_req_o   = (cnt_q != '0);
  assign res_id_o    = id_q[read_pnt_q];
  assign res_addr_o  = addr_q[read_pnt_q];
  assign res_wdata_o = wdata_q[read_pnt_q];
  assign res_be_o    = be_q[read_pnt_q];

  // Entry freed on grant
  assign pop_o = res_req_o && res_gnt_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[write_pnt_q]    <= push_id_i;
      addr_q[write_pnt_q]  <= push_addr_i;
      wdata_q[write_pnt_q] <= push_wdata_i;
      be_q[write_pnt_q]    <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_pnt_q <= 1'b0;
      read_pnt_q  <= 1'b0;
      cnt_q       <= '0;
    end else begin
      if (push_i) begin
        write_pnt_q <= !write_pnt_q;
      end
      if (pop_o) begin
        read_pnt_q <= !read_pnt_q;
      end
      // Push and pop in one cycle keep the count
      cnt_q <= cnt_q + 2'(push_i) - 2'(pop_o);
    end
  end

endmodule

//--- design/valu_issue_ctrl.sv
// Issues one word per cycle; the word address assumes vd * VRegWords fits in VAddrWidth bits
`timescale 1ns/1ps

module valu_issue_ctrl #(
  parameter int unsigned VAddrWidth = 10,
  parameter int unsigned VRegWords  = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Head of the instruction queue
  input  logic                    issue_valid_i,
  input  valu_pkg::alu_op_e       issue_op_i,
  input  valu_pkg::vsew_e         issue_vsew_i,
  input  valu_pkg::vlen_t         issue_vl_i,
  input  valu_pkg::vreg_t         issue_vd_i,
  input  valu_pkg::vid_t          issue_id_i,
  input  logic                    issue_use_scalar_i,
  input  valu_pkg::elen_t         issue_scalar_i,
  // Operand ports
  input  logic                    opa_valid_i,
  input  logic                    opb_valid_i,
  input  valu_pkg::elen_t         opa_i,
  input  valu_pkg::elen_t         opb_i,
  output logic                    opa_ready_o,
  output logic                    opb_ready_o,
  output logic                    issue_done_o,
  // Result queue write side
  input  logic                    rq_full_i,
  output logic                    push_o,
  output valu_pkg::vid_t          push_id_o,
  output logic [VAddrWidth-1:0]   push_addr_o,
  output valu_pkg::strb_t         push_be_o,
  output valu_pkg::elen_t         push_wdata_o
);

  import valu_pkg::*;

  ////////////////////////////////////////
  // Element accounting
  ////////////////////////////////////////

  // Counter is live after the first word of an instruction
  logic  busy_q;
  vlen_t rem_q;

  vlen_t per_word;
  vlen_t rem_cur;
  vlen_t elem_cnt;
  vlen_t rem_next;
  vlen_t word_idx;
  logic  fire;

  logic [3:0]         nbytes;
  logic [StrbWidth:0] be_mask;

  assign per_word = vlen_t'(StrbWidth) >> issue_vsew_i;
  assign rem_cur  = busy_q ? rem_q : issue_vl_i;
  // Partial last word covers only what is left
  assign elem_cnt = (rem_cur < per_word) ? rem_cur : per_word;
  assign rem_next = rem_cur - elem_cnt;
  // All earlier words were full, so this is the word index
  assign word_idx = (issue_vl_i - rem_cur) >> (int'(EW64) - int'(issue_vsew_i));

  // Needs both operands, scalar replaces a, and room in the result queue
  assign fire = issue_valid_i && !rq_full_i && opb_valid_i &&
                (opa_valid_i || issue_use_scalar_i);

  assign opa_ready_o  = fire && !issue_use_scalar_i;
  assign opb_ready_o  = fire;
  assign push_o       = fire;
  assign issue_done_o = fire && (rem_next == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      rem_q  <= '0;
    end else if (fire) begin
      busy_q <= (rem_next != '0);
      rem_q  <= rem_next;
    end
  end

  ////////////////////////////////////////
  // Word payload
  ////////////////////////////////////////

  // Low bytes of the active elements
  assign nbytes    = 4'(elem_cnt << issue_vsew_i);
  assign be_mask   = ({{StrbWidth{1'b0}}, 1'b1} << nbytes) - 1'b1;
  assign push_be_o = be_mask[StrbWidth-1:0];

  assign push_id_o   = issue_id_i;
  assign push_addr_o = VAddrWidth'(int'(issue_vd_i) * VRegWords + int'(word_idx));

  // Scalar low element copied into every slot
  elen_t scalar_bc;
  elen_t operand_a;

  always_comb begin
    unique case (issue_vsew_i)
      EW8:     scalar_bc = {8{issue_scalar_i[7:0]}};
      EW16:    scalar_bc = {4{issue_scalar_i[15:0]}};
      EW32:    scalar_bc = {2{issue_scalar_i[31:0]}};
      default: scalar_bc = issue_scalar_i;
    endcase
  end

  assign operand_a = issue_use_scalar_i ? scalar_bc : opa_i;

  valu_simd_alu i_simd_alu (
    .opa_i    (operand_a),
    .opb_i    (opb_i),
    .op_i     (issue_op_i),
    .vsew_i   (issue_vsew_i),
    .result_o (push_wdata_o)
  );

endmodule

//--- design/valu_insn_queue.sv
// Depth must be a power of two of at least 2; instructions with vl of zero must not be sent
`timescale 1ns/1ps

module valu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Instruction port
  input  logic                             insn_valid_i,
  output logic                             insn_ready_o,
  input  valu_pkg::alu_op_e                insn_op_i,
  input  valu_pkg::vsew_e                  insn_vsew_i,
  input  valu_pkg::vlen_t                  insn_vl_i,
  input  valu_pkg::vreg_t                  insn_vd_i,
  input  valu_pkg::vid_t                   insn_id_i,
  input  logic                             insn_use_scalar_i,
  input  valu_pkg::elen_t                  insn_scalar_i,
  // Head of the issue phase
  output logic                             issue_valid_o,
  output valu_pkg::alu_op_e                issue_op_o,
  output valu_pkg::vsew_e                  issue_vsew_o,
  output valu_pkg::vlen_t                  issue_vl_o,
  output valu_pkg::vreg_t                  issue_vd_o,
  output valu_pkg::vid_t                   issue_id_o,
  output logic                             issue_use_scalar_o,
  output valu_pkg::elen_t                  issue_scalar_o,
  input  logic                             issue_done_i,
  // Commit side
  input  logic                             pop_i,
  output logic [valu_pkg::NrInsnIds-1:0]   done_o
);

  import valu_pkg::*;

  localparam int unsigned PtrWidth = $clog2(InsnQueueDepth);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   cnt_t;

  ////////////////////////////////////////
  // Instruction store
  ////////////////////////////////////////

  alu_op_e op_q         [InsnQueueDepth];
  vsew_e   vsew_q       [InsnQueueDepth];
  vlen_t   vl_q         [InsnQueueDepth];
  vreg_t   vd_q         [InsnQueueDepth];
  vid_t    id_q         [InsnQueueDepth];
  logic    use_scalar_q [InsnQueueDepth];
  elen_t   scalar_q     [InsnQueueDepth];

  // One pointer per phase: accept, issue, commit
  ptr_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue, and not yet committed
  cnt_t issue_cnt_q, commit_cnt_q;

  logic accept;
  logic commit_valid;
  logic commit_done;

  // Pointers wrap at the queue depth
  function automatic ptr_t bump(ptr_t pnt);
    return (pnt == ptr_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Full only when every slot is still uncommitted
  assign insn_ready_o = (commit_cnt_q < cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= insn_op_i;
      vsew_q[accept_pnt_q]       <= insn_vsew_i;
      vl_q[accept_pnt_q]         <= insn_vl_i;
      vd_q[accept_pnt_q]         <= insn_vd_i;
      id_q[accept_pnt_q]         <= insn_id_i;
      use_scalar_q[accept_pnt_q] <= insn_use_scalar_i;
      scalar_q[accept_pnt_q]     <= insn_scalar_i;
    end
  end

  // Issue head, read straight from the store
  assign issue_valid_o      = (issue_cnt_q != '0);
  assign issue_op_o         = op_q[issue_pnt_q];
  assign issue_vsew_o       = vsew_q[issue_pnt_q];
  assign issue_vl_o         = vl_q[issue_pnt_q];
  assign issue_vd_o         = vd_q[issue_pnt_q];
  assign issue_id_o         = id_q[issue_pnt_q];
  assign issue_use_scalar_o = use_scalar_q[issue_pnt_q];
  assign issue_scalar_o     = scalar_q[issue_pnt_q];

  ////////////////////////////////////////
  // Commit element counter
  ////////////////////////////////////////

  // Counter is live once the head has seen its first pop
  logic  commit_busy_q;
  vlen_t commit_rem_q;
  vlen_t commit_rem;
  vlen_t commit_per_word;

  assign commit_valid    = (commit_cnt_q != '0);
  assign commit_per_word = vlen_t'(StrbWidth) >> vsew_q[commit_pnt_q];
  // Fresh head starts from its full vl
  assign commit_rem      = commit_busy_q ? commit_rem_q : vl_q[commit_pnt_q];
  // Last word of the head leaves on this grant
  assign commit_done     = commit_valid && pop_i && (commit_rem <= commit_per_word);

  always_comb begin
    done_o = '0;
    if (commit_done) begin
      done_o[id_q[commit_pnt_q]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      commit_busy_q <= 1'b0;
      commit_rem_q  <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done);
      if (commit_done) begin
        // Release the slot, next head reloads from its vl
        commit_pnt_q  <= bump(commit_pnt_q);
        commit_busy_q <= 1'b0;
      end else if (commit_valid && pop_i) begin
        commit_busy_q <= 1'b1;
        commit_rem_q  <= commit_rem - commit_per_word;
      end
    end
  end

endmodule

//--- design/valu_simd_alu.sv
// Purely combinational; lanes wrap within the element width, no carry crosses elements
`timescale 1ns/1ps

module valu_simd_alu (
  input  valu_pkg::elen_t   opa_i,
  input  valu_pkg::elen_t   opb_i,
  input  valu_pkg::alu_op_e op_i,
  input  valu_pkg::vsew_e   vsew_i,
  output valu_pkg::elen_t   result_o
);

  import valu_pkg::*;

  // Full word result for each element width
  elen_t res_by_ew [4];

  ////////////////////////////////////////
  // Element slices per width
  ////////////////////////////////////////

  for (genvar gw = 0; gw < 4; gw++) begin : g_ew
    localparam int unsigned EW = 8 << gw;

    for (genvar ge = 0; ge < ElenWidth / EW; ge++) begin : g_elem
      logic [EW-1:0] a_e;
      logic [EW-1:0] b_e;
      logic [EW-1:0] r_e;

      assign a_e = opa_i[EW*ge +: EW];
      assign b_e = opb_i[EW*ge +: EW];

      // Width of the slice drops the carry out
      always_comb begin
        case (op_i)
          OP_ADD:  r_e = a_e + b_e;
          OP_SUB:  r_e = a_e - b_e;
          OP_AND:  r_e = a_e & b_e;
          OP_OR:   r_e = a_e | b_e;
          OP_XOR:  r_e = a_e ^ b_e;
          // Unsigned minimum
          OP_MINU: r_e = (a_e < b_e) ? a_e : b_e;
          default: r_e = '0;
        endcase
      end

      assign res_by_ew[gw][EW*ge +: EW] = r_e;
    end
  end

  // Pick the lane layout of the current instruction
  assign result_o = res_by_ew[vsew_i];

endmodule

//--- design/valu_pkg.sv
// Shared widths and types of the vector ALU lane; one 64-bit word per cycle, vl up to 1023
package valu_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // One datapath word
  localparam int unsigned ElenWidth = 64;
  // Byte enables per word
  localparam int unsigned StrbWidth = ElenWidth / 8;
  // Instruction ids in flight, one done bit each
  localparam int unsigned NrInsnIds = 8;

  typedef logic [ElenWidth-1:0]         elen_t;
  typedef logic [StrbWidth-1:0]         strb_t;
  // Vector length or remaining element count
  typedef logic [9:0]                   vlen_t;
  typedef logic [$clog2(NrInsnIds)-1:0] vid_t;
  // Vector register index
  typedef logic [4:0]                   vreg_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Element width, value is log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Integer operations of the SIMD datapath
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MINU = 3'd5
  } alu_op_e;

endpackage
